//--- source/spi_cmd_pkg.sv
package spi_cmd_pkg;

  // A command word is {op, addr, data}, sent most significant bit first.
  localparam int unsigned ADDR_BITS = 3;
  localparam int unsigned DATA_BITS = 8;
  localparam int unsigned CMD_BITS  = 1 + ADDR_BITS + DATA_BITS;

  localparam int unsigned CMD_OP_BIT = CMD_BITS - 1;  // Set for a write, clear for a read.
  localparam int unsigned ADDR_LSB   = DATA_BITS;

  // Bits per chip-select window.
  localparam int unsigned WRITE_BITS     = CMD_BITS;
  localparam int unsigned READ_ADDR_BITS = 1 + ADDR_BITS;  // Operation bit plus address.
  localparam int unsigned READ_DATA_BITS = DATA_BITS;

  // Wide enough to count the bits of the longest window.
  localparam int unsigned BIT_CNT_W = $clog2(WRITE_BITS);

  typedef logic [CMD_BITS-1:0]       cmd_word_t;
  typedef logic [READ_DATA_BITS-1:0] rsp_byte_t;

endpackage

//--- source/spi_timing_pkg.sv
package spi_timing_pkg;

  // Clock cycles per half period of sclk.
  localparam int unsigned DEF_HALF_PERIOD = 4;

  // Cycles that cs_n stays high between the address and data windows of a read.
  localparam int unsigned DEF_TURN_CYCLES = 100;

  localparam int unsigned DEF_CMD_DEPTH = 4;  // Command queue entries.
  localparam int unsigned DEF_RSP_DEPTH = 4;  // Response queue entries.

endpackage

//--- source/spi_queue.sv
module spi_queue #(
  parameter int unsigned DEPTH     = spi_timing_pkg::DEF_CMD_DEPTH,
  parameter type         payload_t = spi_cmd_pkg::cmd_word_t
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     not_empty,
  output logic     not_full
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Pointers wrap explicitly so any depth works, not only powers of two.
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;     // Both or neither leave the occupancy unchanged.
      endcase
    end
  end

  assign head      = mem[rd_ptr];  // Written data shows here one cycle after the push.
  assign not_empty = (count != '0);
  assign not_full  = (count != CNT_W'(DEPTH));

  // The producer must respect not_full and the consumer not_empty.
  no_push_when_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    push |-> not_full
  ) else $error("spi_queue: push while full");

  no_pop_when_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    pop |-> not_empty
  ) else $error("spi_queue: pop while empty");

endmodule

//--- source/spi_frame_engine.sv
module spi_frame_engine #(
  parameter int unsigned HALF_PERIOD = spi_timing_pkg::DEF_HALF_PERIOD,
  parameter int unsigned TURN_CYCLES = spi_timing_pkg::DEF_TURN_CYCLES
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  spi_cmd_pkg::cmd_word_t cmd_head,
  input  logic                   cmd_avail,
  output logic                   cmd_take,
  input  logic                   rsp_space,
  output logic                   rsp_push,
  output spi_cmd_pkg::rsp_byte_t rsp_byte,
  output logic                   sclk,
  output logic                   cs_n,
  output logic                   mosi,
  input  logic                   miso
);

  import spi_cmd_pkg::*;

  // One timer paces both the sclk half periods and the read turnaround.
  localparam int unsigned MAX_CNT = (TURN_CYCLES > HALF_PERIOD) ? TURN_CYCLES : HALF_PERIOD;
  localparam int unsigned CNT_W   = $clog2(MAX_CNT + 1);

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    SHIFT_OUT,
    TURN,
    SHIFT_IN,
    DONE
  } state_t;

  state_t               state;
  state_t               state_nxt;
  logic [CNT_W-1:0]     tmr;
  logic [BIT_CNT_W-1:0] bit_cnt;
  cmd_word_t            shreg;
  logic                 is_read;
  logic                 can_start;
  logic                 half_done;
  logic                 turn_done;
  logic                 last_bit;
  logic                 sclk_rise;
  logic                 sclk_fall;
  logic                 win_end;

  // A read may only start if its byte is sure to find room in the response queue.
  assign can_start = cmd_avail & (cmd_head[CMD_OP_BIT] | rsp_space);

  assign half_done = (tmr == CNT_W'(HALF_PERIOD - 1));
  assign turn_done = (tmr == CNT_W'(TURN_CYCLES - 1));
  assign sclk_rise = half_done & ~sclk;
  assign sclk_fall = half_done & sclk;
  assign win_end   = sclk_fall & last_bit;  // Falling edge after the window's last bit.

  always_comb
  begin
    if (state == SHIFT_IN)
      last_bit = (bit_cnt == BIT_CNT_W'(READ_DATA_BITS - 1));
    else if (is_read)
      last_bit = (bit_cnt == BIT_CNT_W'(READ_ADDR_BITS - 1));
    else
      last_bit = (bit_cnt == BIT_CNT_W'(WRITE_BITS - 1));
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
        if (can_start)
          state_nxt = LOAD;
      LOAD:
        state_nxt = SHIFT_OUT;
      SHIFT_OUT:
        if (win_end)
          state_nxt = is_read ? TURN : DONE;
      TURN:
        if (turn_done)
          state_nxt = SHIFT_IN;
      SHIFT_IN:
        if (win_end)
          state_nxt = DONE;
      DONE:
        state_nxt = IDLE;
      default:
        state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      tmr     <= '0;
      bit_cnt <= '0;
      is_read <= 1'b0;
      sclk    <= 1'b0;
      cs_n    <= 1'b1;
      mosi    <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      case (state)
        LOAD:
        begin
          cs_n    <= 1'b0;                     // Window opens the cycle after the pop.
          mosi    <= cmd_head[CMD_OP_BIT];
          is_read <= ~cmd_head[CMD_OP_BIT];
          bit_cnt <= '0;
          tmr     <= '0;
        end
        SHIFT_OUT, SHIFT_IN:
        begin
          if (half_done)
          begin
            tmr  <= '0;
            sclk <= ~sclk;
          end
          else
          begin
            tmr <= tmr + 1'b1;
          end
          // In mode 0 mosi moves with the falling edge and stays put while sclk is high.
          if (sclk_fall)
          begin
            bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
            mosi    <= (state == SHIFT_OUT && !last_bit) ? shreg[CMD_OP_BIT-1] : 1'b0;
            if (last_bit)
              cs_n <= 1'b1;
          end
        end
        TURN:
        begin
          if (turn_done)
          begin
            tmr  <= '0;
            cs_n <= 1'b0;
          end
          else
          begin
            tmr <= tmr + 1'b1;
          end
        end
        default:
        begin
          tmr  <= '0;
          sclk <= 1'b0;
        end
      endcase
    end
  end

  // Outgoing bits leave from the top; incoming bits enter at the bottom.
  always_ff @(posedge clk)
  begin
    if (state == LOAD)
      shreg <= cmd_head;
    else if (state == SHIFT_OUT && sclk_fall)
      shreg <= shreg << 1;
    else if (state == SHIFT_IN && sclk_rise)
      shreg <= {shreg[CMD_BITS-2:0], miso};
  end

  assign cmd_take = (state == LOAD);
  assign rsp_push = (state == DONE) & is_read;  // First cycle with cs_n high again.
  assign rsp_byte = shreg[READ_DATA_BITS-1:0];

  cs_high_in_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == IDLE) |-> cs_n
  ) else $error("spi_frame_engine: cs_n low while idle");

  sclk_low_outside_window: assert property (
    @(posedge clk) disable iff (!rst_n)
    cs_n |-> !sclk
  ) else $error("spi_frame_engine: sclk high with cs_n high");

  // Room was checked when the read started; the byte lands many cycles later.
  push_only_with_space: assert property (
    @(posedge clk) disable iff (!rst_n)
    rsp_push |-> rsp_space
  ) else $error("spi_frame_engine: response pushed without space");

endmodule

//--- source/spi_access_top.sv
module spi_access_top #(
  parameter int unsigned HALF_PERIOD = spi_timing_pkg::DEF_HALF_PERIOD,
  parameter int unsigned TURN_CYCLES = spi_timing_pkg::DEF_TURN_CYCLES,
  parameter int unsigned CMD_DEPTH   = spi_timing_pkg::DEF_CMD_DEPTH,
  parameter int unsigned RSP_DEPTH   = spi_timing_pkg::DEF_RSP_DEPTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  spi_cmd_pkg::cmd_word_t cmd_in,
  input  logic                   cmd_vld,
  output logic                   cmd_rdy,
  output logic                   rsp_vld,
  output spi_cmd_pkg::rsp_byte_t rsp_data,
  input  logic                   rsp_rd,
  output logic                   sclk,
  output logic                   cs_n,
  output logic                   mosi,
  input  logic                   miso
);

  import spi_cmd_pkg::*;

  cmd_word_t cmd_head;
  logic      cmd_push;
  logic      cmd_avail;
  logic      cmd_take;
  rsp_byte_t rsp_byte;
  logic      rsp_push;
  logic      rsp_space;

  assign cmd_push = cmd_vld & cmd_rdy;  // A held word is taken once room appears.

  spi_queue #(
    .DEPTH     (CMD_DEPTH),
    .payload_t (cmd_word_t)
  ) cmd_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (cmd_push),
    .push_data (cmd_in),
    .pop       (cmd_take),
    .head      (cmd_head),
    .not_empty (cmd_avail),
    .not_full  (cmd_rdy)
  );

  spi_frame_engine #(
    .HALF_PERIOD (HALF_PERIOD),
    .TURN_CYCLES (TURN_CYCLES)
  ) u_frame_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_head  (cmd_head),
    .cmd_avail (cmd_avail),
    .cmd_take  (cmd_take),
    .rsp_space (rsp_space),
    .rsp_push  (rsp_push),
    .rsp_byte  (rsp_byte),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso)
  );

  spi_queue #(
    .DEPTH     (RSP_DEPTH),
    .payload_t (rsp_byte_t)
  ) rsp_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (rsp_push),
    .push_data (rsp_byte),
    .pop       (rsp_rd),
    .head      (rsp_data),
    .not_empty (rsp_vld),
    .not_full  (rsp_space)
  );

endmodule

//--- testbench/spi_slave_model.sv
module spi_slave_model (
  input  logic                   sclk,
  input  logic                   cs_n,
  input  logic                   mosi,
  output logic                   miso,
  output spi_cmd_pkg::cmd_word_t frame_bits,
  output int unsigned            frame_len,
  output int unsigned            bad_frames
);

  import spi_cmd_pkg::*;

  rsp_byte_t        regs [8];
  cmd_word_t        shift_in;
  rsp_byte_t        shift_out;
  logic [ADDR_BITS-1:0] read_addr;
  logic             read_armed = 1'b0;
  logic             data_phase = 1'b0;
  logic             in_window  = 1'b0;  // Ignores the cs_n edge that reset produces.
  int unsigned      bit_cnt;

  initial
  begin
    miso       = 1'b0;
    frame_bits = '0;
    frame_len  = 0;
    bad_frames = 0;
    for (int i = 0; i < 8; i++)
      regs[i] = 8'(i * 37) ^ 8'h5a;
  end

  always @(negedge cs_n)
  begin
    in_window  = 1'b1;
    bit_cnt    = 0;
    shift_in   = '0;
    data_phase = read_armed;  // The window after an address phase returns data.
    if (read_armed)
    begin
      shift_out = regs[read_addr];
      miso      = shift_out[READ_DATA_BITS-1];
      shift_out = shift_out << 1;
    end
  end

  always @(posedge sclk)
  begin
    if (!cs_n)
    begin
      shift_in = {shift_in[CMD_BITS-2:0], mosi};
      bit_cnt++;
    end
  end

  // Mode 0 data moves on the falling edge, half a bit ahead of the master's sample.
  always @(negedge sclk)
  begin
    if (!cs_n && data_phase)
    begin
      miso      = shift_out[READ_DATA_BITS-1];
      shift_out = shift_out << 1;
    end
  end

  always @(posedge cs_n)
  begin
    if (in_window)
    begin
      in_window  = 1'b0;
      frame_bits = shift_in;
      frame_len  = bit_cnt;
      miso       = 1'b0;
      if (data_phase)
      begin
        read_armed = 1'b0;
        if (bit_cnt != READ_DATA_BITS)
        begin
          bad_frames++;
          $display("Slave model: read data window had %0d clocks instead of %0d.",
                   bit_cnt, READ_DATA_BITS);
        end
      end
      else if (bit_cnt == WRITE_BITS && shift_in[CMD_OP_BIT])
        regs[shift_in[ADDR_LSB +: ADDR_BITS]] = shift_in[DATA_BITS-1:0];
      else if (bit_cnt == READ_ADDR_BITS && !shift_in[READ_ADDR_BITS-1])
      begin
        read_addr  = shift_in[ADDR_BITS-1:0];
        read_armed = 1'b1;
      end
      else
      begin
        bad_frames++;
        $display("Slave model: a %0d-bit frame with value %0h does not decode.",
                 bit_cnt, shift_in);
      end
    end
  end

endmodule

//--- testbench/tb_spi_access.sv
module tb_spi_access;

  import spi_cmd_pkg::*;
  import spi_timing_pkg::*;

  localparam int unsigned HALF_PERIOD = 2;
  localparam int unsigned TURN_CYCLES = 10;
  localparam int unsigned CLK_PERIOD  = 10;
  localparam int unsigned DRIVE_DLY   = 2;
  localparam logic [15:0] SEED        = 16'd28209;
  localparam int unsigned N_RANDOM    = 40;
  localparam int unsigned N_HELD      = 7;
  localparam int unsigned MAX_FRAME   = 24 * HALF_PERIOD + TURN_CYCLES + 8;
  localparam int unsigned WATCHDOG_CYCLES = (8 + N_RANDOM + N_HELD) * MAX_FRAME * 2 + 1000;

  logic        clk = 1'b0;
  logic        rst_n;
  cmd_word_t   cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        rsp_vld;
  rsp_byte_t   rsp_data;
  logic        rsp_rd;
  logic        sclk;
  logic        cs_n;
  logic        mosi;
  logic        miso;
  cmd_word_t   slave_frame;
  int unsigned slave_len;
  int unsigned slave_bad;

  logic [15:0] stim_lfsr  = SEED;
  logic [15:0] drain_lfsr = SEED;
  logic        drain_en;
  rsp_byte_t   model_regs [8];
  cmd_word_t   sent_q [$];    // Accepted commands whose frames are not finished.
  rsp_byte_t   exp_q [$];     // Bytes the host still expects, in command order.
  int unsigned errors, accepted, reads_accepted, started, done_cmds, reads_done, drained;
  int unsigned rdy_stalls;

  spi_access_top #(
    .HALF_PERIOD (HALF_PERIOD),
    .TURN_CYCLES (TURN_CYCLES)
  ) UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .rsp_vld  (rsp_vld),
    .rsp_data (rsp_data),
    .rsp_rd   (rsp_rd),
    .sclk     (sclk),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .miso     (miso)
  );

  spi_slave_model slave (
    .sclk       (sclk),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .miso       (miso),
    .frame_bits (slave_frame),
    .frame_len  (slave_len),
    .bad_frames (slave_bad)
  );

  initial
  begin : clock_gen
    forever
      #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      errors++;
      $display("ERROR %s: expected 'h%0h, got 'h%0h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s (at %0t)", what, $time);
  endtask

  // A Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int unsigned n, output logic [11:0] value);
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      value     = {value[10:0], stim_lfsr[0]};
      stim_lfsr = lfsr_next(stim_lfsr);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic verify_reset_outputs();
    check_value("cs_n", 1, cs_n);
    check_value("sclk", 0, sclk);
    check_value("rsp_vld", 0, rsp_vld);
    check_value("cmd_rdy", 1, cmd_rdy);
  endtask

  // Holds the word until cmd_rdy lets it in, then updates the reference model.
  task automatic send_cmd(input cmd_word_t word);
    cmd_in  = word;
    cmd_vld = 1'b1;
    check_value("cmd_rdy", 32'(accepted - started < DEF_CMD_DEPTH), 32'(cmd_rdy));
    while (!cmd_rdy)
    begin
      rdy_stalls++;
      next_cycle();
      check_value("cmd_rdy", 32'(accepted - started < DEF_CMD_DEPTH), 32'(cmd_rdy));
    end
    next_cycle();
    cmd_vld = 1'b0;
    accepted++;
    sent_q.push_back(word);
    if (word[CMD_OP_BIT])
      model_regs[word[ADDR_LSB +: ADDR_BITS]] = word[DATA_BITS-1:0];
    else
    begin
      reads_accepted++;
      exp_q.push_back(model_regs[word[ADDR_LSB +: ADDR_BITS]]);
    end
  endtask

  task automatic wait_idle();
    while (done_cmds != accepted || drained != reads_accepted)
      next_cycle();
  endtask

  initial
  begin : frame_monitor
    time       t_fall;
    time       t_rise;
    logic      in_read;
    cmd_word_t cmd;
    in_read = 1'b0;
    t_rise  = 0;
    @(posedge rst_n);
    forever
    begin
      @(negedge cs_n);
      t_fall = $time;
      if (in_read)
        check_value("cs_n turnaround cycles", TURN_CYCLES, 32'((t_fall - t_rise) / CLK_PERIOD));
      else
      begin
        started++;
        if (sent_q.size() > 0 && !sent_q[0][CMD_OP_BIT] && reads_done - drained >= DEF_RSP_DEPTH)
          report_failure("A read started while the response queue was full.");
      end
      @(posedge cs_n);
      t_rise = $time;
      #1;  // Lets the slave model finish decoding the window.
      if (in_read)
      begin
        in_read = 1'b0;
        reads_done++;
        done_cmds++;
        check_value("cs_n low cycles, read data", 16 * HALF_PERIOD,
                    32'((t_rise - t_fall) / CLK_PERIOD));
        check_value("slave data bit count", READ_DATA_BITS, slave_len);
        if (reads_done - drained > DEF_RSP_DEPTH)
          report_failure("More response bytes are pending than the queue can hold.");
      end
      else if (sent_q.size() == 0)
        report_failure("A frame appeared on the bus with no command outstanding.");
      else
      begin
        cmd     = sent_q.pop_front();
        in_read = !cmd[CMD_OP_BIT];
        if (in_read)
        begin
          check_value("cs_n low cycles, read address", 8 * HALF_PERIOD,
                      32'((t_rise - t_fall) / CLK_PERIOD));
          check_value("slave address bit count", READ_ADDR_BITS, slave_len);
          check_value("mosi address frame", cmd[CMD_OP_BIT -: READ_ADDR_BITS],
                      slave_frame[READ_ADDR_BITS-1:0]);
        end
        else
        begin
          done_cmds++;
          check_value("cs_n low cycles, write", 24 * HALF_PERIOD,
                      32'((t_rise - t_fall) / CLK_PERIOD));
          check_value("slave write bit count", WRITE_BITS, slave_len);
          check_value("mosi write frame", cmd, slave_frame);
        end
      end
    end
  end

  initial
  begin : response_drain
    logic take;
    rsp_rd = 1'b0;
    @(posedge rst_n);
    forever
    begin
      next_cycle();
      take = 1'b0;
      if (drain_en && rsp_vld)
      begin
        take       = drain_lfsr[0];
        drain_lfsr = lfsr_next(drain_lfsr);
      end
      if (take)
      begin
        if (exp_q.size() == 0)
          report_failure("A response byte arrived with no read outstanding.");
        else
          check_value("rsp_data", exp_q.pop_front(), rsp_data);
        drained++;
      end
      rsp_rd = take;
    end
  end

  initial
  begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles.", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial
  begin : stimulus
    logic [11:0] r;
    cmd_in   = '0;
    cmd_vld  = 1'b0;
    rst_n    = 1'b0;
    drain_en = 1'b1;
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    verify_reset_outputs();
    rst_n = 1'b1;
    next_cycle();
    verify_reset_outputs();

    // Back-to-back writes give every register a known value and fill the command queue.
    for (int a = 0; a < 8; a++)
    begin
      draw_bits(DATA_BITS, r);
      send_cmd({1'b1, 3'(a), r[DATA_BITS-1:0]});
    end
    wait_idle();
    if (rdy_stalls == 0)
      report_failure("cmd_rdy never dropped while commands were held back to back.");

    for (int i = 0; i < N_RANDOM; i++)
    begin
      draw_bits(2, r);
      repeat (r[1:0])
        next_cycle();
      draw_bits(CMD_BITS, r);
      send_cmd(r);
    end
    wait_idle();

    drain_en = 1'b0;  // Reads pile up, then the rest must wait for room.
    for (int i = 0; i < N_HELD; i++)
    begin
      draw_bits(ADDR_BITS, r);
      send_cmd({1'b0, r[ADDR_BITS-1:0], 8'h00});
    end
    while (reads_done - drained < DEF_RSP_DEPTH)
      next_cycle();
    repeat (2 * MAX_FRAME)
      next_cycle();
    check_value("pending response bytes", DEF_RSP_DEPTH, reads_done - drained);
    check_value("rsp_vld", 1, rsp_vld);
    if (reads_done == reads_accepted)
      report_failure("All held reads finished although the response queue was full.");
    drain_en = 1'b1;
    wait_idle();

    $display("Errors: %0d failed checks, %0d bad slave frames", errors, slave_bad);
    if (errors == 0 && slave_bad == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

//--- vlog.f
source/spi_cmd_pkg.sv
source/spi_timing_pkg.sv
source/spi_queue.sv
source/spi_frame_engine.sv
source/spi_access_top.sv
testbench/spi_slave_model.sv
testbench/tb_spi_access.sv

//--- Bender.yml
package:
  name: spi_access

sources:
  - source/spi_cmd_pkg.sv
  - source/spi_timing_pkg.sv
  - source/spi_queue.sv
  - source/spi_frame_engine.sv
  - source/spi_access_top.sv
  - target: test
    files:
      - testbench/spi_slave_model.sv
      - testbench/tb_spi_access.sv
